// ==== project.f ====
hdl/csr_pkg.sv
hdl/trap_pkg.sv
hdl/csr_regfile.sv
hdl/trap_sequencer.sv
hdl/mret_sequencer.sv
hdl/csr_rmw_unit.sv
hdl/trap_unit_top.sv
tests/trap_unit_assert.sv
tests/tb_trap_unit.sv

// ==== Bender.yml ====
package:
  name: trap_unit

sources:
  # Packages first, then the design from the leaves up
  - files:
      - hdl/csr_pkg.sv
      - hdl/trap_pkg.sv
      - hdl/csr_regfile.sv
      - hdl/trap_sequencer.sv
      - hdl/mret_sequencer.sv
      - hdl/csr_rmw_unit.sv
      - hdl/trap_unit_top.sv

  - target: test
    files:
      - tests/trap_unit_assert.sv
      - tests/tb_trap_unit.sv

// ==== tests/tb_trap_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_trap_unit;

   import csr_pkg::*;
   import trap_pkg::*;

   localparam int CLK_PERIOD      = 100;
   localparam int NUM_TESTS       = 6;
   localparam int WATCHDOG_CYCLES = NUM_TESTS * 200;

   logic      clk;
   logic      reset;
   logic      exc_valid;
   exc_kind_t exc_kind;
   xlen_t     pc;
   logic      timer_irq;
   logic      tag_irq;
   logic      mret;
   csr_cmd_t  csr_cmd;
   redirect_t trap_o;
   redirect_t mret_o;
   logic      csr_done;
   xlen_t     csr_old;
   logic      trap_busy;
   logic      mret_busy;

   int        seed = 78584;
   int        errors = 0;
   int        fails_at_start = 0;
   int        tests_failed = 0;
   int        test_num = 0;
   int        busy_cycles;
   xlen_t     rd;
   xlen_t     old;
   xlen_t     rs1;
   xlen_t     operand;
   xlen_t     pc_val;
   logic [4:0] zimm;

   // Registers exercised by software access and their reset values
   csr_op_t   ops [6]    = '{CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI};
   csr_addr_t addrs [3]  = '{CSR_MTVEC, CSR_MIE, CSR_MEPC};
   xlen_t     shadow [3] = '{32'd16, 32'd0, 32'd0};

   trap_unit_top #(
      .MTVEC_RESET (32'd16)
   ) dut0 (
      .clk         (clk),
      .reset       (reset),
      .exc_valid_i (exc_valid),
      .exc_kind_i  (exc_kind),
      .pc_i        (pc),
      .timer_irq_i (timer_irq),
      .tag_irq_i   (tag_irq),
      .mret_i      (mret),
      .csr_cmd_i   (csr_cmd),
      .trap_o      (trap_o),
      .mret_o      (mret_o),
      .csr_done_o  (csr_done),
      .csr_old_o   (csr_old),
      .trap_busy_o (trap_busy),
      .mret_busy_o (mret_busy)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
   end

   // ========================================
   // Helpers
   // ========================================
   task automatic drive_point();
      @(posedge clk);
      #5;   // Inputs change just after the edge
   endtask

   function automatic int total_failures();
      return errors + dut0.assert0.fail_count;
   endfunction

   task automatic expect_equal(input string name, input xlen_t expected, input xlen_t actual);
      assert (actual === expected)
      else begin
         $display("ERROR at %0t: %s expected 0x%08h, got 0x%08h", $time, name, expected, actual);
         errors++;
      end
   endtask

   task automatic csr_access(input csr_op_t op, input csr_addr_t addr, input xlen_t rs1_val,
                             input logic [4:0] imm, output xlen_t old_val);
      int waited;
      waited = 0;
      old_val = '0;
      drive_point();
      csr_cmd = '{valid: 1'b1, op: op, addr: addr, rs1_val: rs1_val, zimm: imm};
      drive_point();
      csr_cmd.valid = 1'b0;
      @(negedge clk);
      while (!csr_done && waited < 10) begin
         waited++;
         @(negedge clk);
      end
      if (csr_done) begin
         expect_equal("csr_done_o latency", 32'd0, waited);
         old_val = csr_old;
      end else begin
         $display("CSR access to 0x%03h never completed at %0t", addr, $time);
         errors++;
      end
   endtask

   task automatic csr_read(input csr_addr_t addr, output xlen_t value);
      csr_access(CSRRS, addr, 32'd0, 5'd0, value);   // Set with zero
   endtask

   task automatic csr_write(input csr_addr_t addr, input xlen_t value);
      xlen_t unused;
      csr_access(CSRRW, addr, value, 5'd0, unused);
   endtask

   // Edges counted from the sampling edge to the start of the pulse
   task automatic check_redirect(input logic from_mret, input int exp_edges,
                                 input xlen_t exp_target);
      redirect_t r;
      int        edges;
      edges = 0;
      @(negedge clk);
      r = from_mret ? mret_o : trap_o;
      while (!r.valid && edges < 20) begin
         edges++;
         @(negedge clk);
         r = from_mret ? mret_o : trap_o;
      end
      if (!r.valid) begin
         $display("Redirect missing: no %s pulse within 20 cycles at %0t",
                  from_mret ? "mret_o" : "trap_o", $time);
         errors++;
      end else begin
         expect_equal(from_mret ? "mret_o latency" : "trap_o latency", exp_edges, edges);
         expect_equal(from_mret ? "mret_o.target" : "trap_o.target", exp_target, r.target);
      end
   endtask

   task automatic finish_test(input string name);
      test_num++;
      if (total_failures() == fails_at_start) begin
         $display("Test %0d %s: passed", test_num, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: failed with %0d errors", test_num, name,
                  total_failures() - fails_at_start);
      end
      fails_at_start = total_failures();
   endtask

   // ========================================
   // Tests
   // ========================================
   initial begin
      exc_valid = 1'b0;
      exc_kind  = ECALL;
      pc        = '0;
      timer_irq = 1'b0;
      tag_irq   = 1'b0;
      mret      = 1'b0;
      csr_cmd   = '0;
      reset     = 1'b1;
      repeat (10) @(posedge clk);
      #5;
      reset = 1'b0;

      csr_read(CSR_MTVEC, rd);
      expect_equal("mtvec", 32'd16, rd);
      csr_read(CSR_MSTATUS, rd);
      expect_equal("mstatus", 32'd0, rd);
      finish_test("reset values");

      for (int a = 0; a < 3; a++) begin
         for (int o = 0; o < 6; o++) begin
            rs1  = $random(seed);
            zimm = $random(seed);
            if (ops[o] == CSRRWI || ops[o] == CSRRSI || ops[o] == CSRRCI) operand = {27'd0, zimm};
            else operand = rs1;
            csr_access(ops[o], addrs[a], rs1, zimm, old);
            expect_equal($sformatf("csr_old_o 0x%03h", addrs[a]), shadow[a], old);
            if (ops[o] == CSRRW || ops[o] == CSRRWI) shadow[a] = operand;
            else if (ops[o] == CSRRS || ops[o] == CSRRSI) shadow[a] = shadow[a] | operand;
            else shadow[a] = shadow[a] & ~operand;
            csr_read(addrs[a], rd);
            expect_equal($sformatf("read-back 0x%03h", addrs[a]), shadow[a], rd);
         end
      end
      finish_test("software CSR access");

      csr_write(CSR_MSTATUS, 32'h0000_0008);
      pc_val = $random(seed);
      drive_point();
      exc_valid = 1'b1;
      exc_kind  = ECALL;
      pc        = pc_val;
      drive_point();
      exc_valid = 1'b0;
      check_redirect(1'b0, 4, shadow[0] & ~32'h1);
      csr_read(CSR_MCAUSE, rd);
      expect_equal("mcause", 32'h0000_000b, rd);
      csr_read(CSR_MEPC, rd);
      expect_equal("mepc", pc_val, rd);
      csr_read(CSR_MTVAL, rd);
      expect_equal("mtval", pc_val, rd);
      csr_read(CSR_MSTATUS, rd);
      expect_equal("mstatus", 32'h0000_0080, rd);   // MPIE takes MIE and MIE clears
      finish_test("ecall trap");

      csr_write(CSR_MIE, 32'h0000_0080);
      csr_write(CSR_MSTATUS, 32'h0000_0008);
      drive_point();
      timer_irq = 1'b1;
      pc        = $random(seed);
      drive_point();
      check_redirect(1'b0, 5, shadow[0] & ~32'h1);
      drive_point();
      timer_irq = 1'b0;
      csr_read(CSR_MCAUSE, rd);
      expect_equal("mcause", 32'h8000_0007, rd);
      csr_read(CSR_MIP, rd);
      expect_equal("mip[7]", 32'd1, rd[7]);
      // Timer pending with the global enable clear
      drive_point();
      timer_irq   = 1'b1;
      busy_cycles = 0;
      repeat (50) begin
         @(negedge clk);
         if (trap_busy || trap_o.valid) busy_cycles++;
      end
      expect_equal("trap_busy_o cycles", 32'd0, busy_cycles);
      drive_point();
      timer_irq = 1'b0;
      finish_test("timer interrupt");

      csr_write(CSR_MIE, 32'h0001_0000);
      csr_write(CSR_MSTATUS, 32'h0000_0008);
      drive_point();
      tag_irq = 1'b1;
      drive_point();
      check_redirect(1'b0, 4, shadow[0] & ~32'h1);
      drive_point();
      tag_irq = 1'b0;
      csr_read(CSR_MCAUSE, rd);
      expect_equal("mcause", 32'h8000_0010, rd);
      csr_write(CSR_MIE, 32'h0001_0080);
      csr_write(CSR_MSTATUS, 32'h0000_0008);
      drive_point();
      tag_irq   = 1'b1;
      timer_irq = 1'b1;   // Timer must win
      drive_point();
      check_redirect(1'b0, 5, shadow[0] & ~32'h1);
      drive_point();
      tag_irq   = 1'b0;
      timer_irq = 1'b0;
      csr_read(CSR_MCAUSE, rd);
      expect_equal("mcause", 32'h8000_0007, rd);
      finish_test("tag interrupt");

      csr_write(CSR_MSTATUS, 32'h0000_0008);
      pc_val = $random(seed) | 32'h1;   // Odd pc
      drive_point();
      exc_valid = 1'b1;
      exc_kind  = EBREAK;
      pc        = pc_val;
      drive_point();
      exc_valid = 1'b0;
      check_redirect(1'b0, 4, shadow[0] & ~32'h1);
      csr_read(CSR_MCAUSE, rd);
      expect_equal("mcause", 32'h0000_0003, rd);
      drive_point();
      mret = 1'b1;
      drive_point();
      mret = 1'b0;
      check_redirect(1'b1, 1, pc_val & ~32'h1);
      csr_read(CSR_MSTATUS, rd);
      expect_equal("mstatus", 32'h0000_0088, rd);   // MIE back from MPIE
      finish_test("mret");

      $display("Tests run: %0d, failed: %0d, checks failed: %0d, assertion failures: %0d",
               test_num, tests_failed, errors, dut0.assert0.fail_count);
      if (total_failures() == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tests/trap_unit_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module trap_unit_assert (
   input wire                       clk,
   input wire                       reset,
   input wire                       exc_valid_i,
   input wire                       mret_i,
   input wire trap_pkg::csr_cmd_t   csr_cmd_i,
   input wire trap_pkg::redirect_t  trap_o,
   input wire trap_pkg::redirect_t  mret_o,
   input wire                       csr_done_o,
   input wire                       trap_busy_o,
   input wire                       mret_busy_o
);

   import trap_pkg::*;

   int unsigned fail_count = 0;

   // ========================================
   // Redirect timing
   // ========================================
   // Busy for four cycles before the pulse, five with the mip step
   trap_latency: assert property (@(posedge clk) disable iff (reset)
      trap_o.valid |-> $past(trap_busy_o, 3) && $past(trap_busy_o, 4)
                       && !($past(trap_busy_o, 5) && $past(trap_busy_o, 6)))
      else begin fail_count++; $error("trap_o.valid at wrong distance from trap start"); end

   mret_latency: assert property (@(posedge clk) disable iff (reset)
      mret_o.valid |-> $past(mret_busy_o) && !$past(mret_busy_o, 2))
      else begin fail_count++; $error("mret_o.valid at wrong distance from mret start"); end

   trap_pulse: assert property (@(posedge clk) disable iff (reset)
      trap_o.valid |-> !$past(trap_o.valid))
      else begin fail_count++; $error("trap_o.valid held longer than one cycle"); end

   mret_pulse: assert property (@(posedge clk) disable iff (reset)
      mret_o.valid |-> !$past(mret_o.valid))
      else begin fail_count++; $error("mret_o.valid held longer than one cycle"); end

   // Core must stay quiet while a sequence runs
   no_req_busy: assert property (@(posedge clk) disable iff (reset)
      (trap_busy_o || mret_busy_o) |-> !(exc_valid_i || mret_i || csr_cmd_i.valid))
      else begin fail_count++; $error("Request issued while a sequencer was busy"); end

   reset_quiet: assert property (@(posedge clk)
      $past(reset) |-> !trap_o.valid && !mret_o.valid && !csr_done_o
                       && !trap_busy_o && !mret_busy_o)
      else begin fail_count++; $error("Outputs not low after reset"); end

endmodule

bind trap_unit_top trap_unit_assert assert0 (
   .clk         (clk),
   .reset       (reset),
   .exc_valid_i (exc_valid_i),
   .mret_i      (mret_i),
   .csr_cmd_i   (csr_cmd_i),
   .trap_o      (trap_o),
   .mret_o      (mret_o),
   .csr_done_o  (csr_done_o),
   .trap_busy_o (trap_busy_o),
   .mret_busy_o (mret_busy_o)
);

`default_nettype wire

// ==== hdl/trap_unit_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module trap_unit_top #(
   parameter csr_pkg::xlen_t MTVEC_RESET = 32'd16
) (
   input  wire                       clk,
   input  wire                       reset,
   input  wire                       exc_valid_i,
   input  wire trap_pkg::exc_kind_t  exc_kind_i,
   input  wire csr_pkg::xlen_t       pc_i,
   input  wire                       timer_irq_i,
   input  wire                       tag_irq_i,
   input  wire                       mret_i,
   input  wire trap_pkg::csr_cmd_t   csr_cmd_i,
   output trap_pkg::redirect_t       trap_o,
   output trap_pkg::redirect_t       mret_o,
   output logic                      csr_done_o,
   output csr_pkg::xlen_t            csr_old_o,
   output logic                      trap_busy_o,
   output logic                      mret_busy_o
);

   import csr_pkg::*;
   import trap_pkg::*;

   csr_req_t trap_csr;
   csr_req_t mret_csr;
   csr_req_t sw_csr;
   xlen_t    rdata;
   logic     irq_enable;
   logic     timer_en;
   logic     tag_en;

   // ========================================
   // CSR file and its three clients
   // ========================================
   csr_regfile #(
      .MTVEC_RESET (MTVEC_RESET)
   ) csr0 (
      .clk          (clk),
      .reset        (reset),
      .trap_csr_i   (trap_csr),
      .mret_csr_i   (mret_csr),
      .sw_csr_i     (sw_csr),
      .rdata_o      (rdata),
      .irq_enable_o (irq_enable),
      .timer_en_o   (timer_en),
      .tag_en_o     (tag_en)
   );

   trap_sequencer trap_seq0 (
      .clk          (clk),
      .reset        (reset),
      .exc_valid_i  (exc_valid_i),
      .exc_kind_i   (exc_kind_i),
      .pc_i         (pc_i),
      .timer_irq_i  (timer_irq_i),
      .tag_irq_i    (tag_irq_i),
      .irq_enable_i (irq_enable),
      .timer_en_i   (timer_en),
      .tag_en_i     (tag_en),
      .rdata_i      (rdata),
      .csr_o        (trap_csr),
      .trap_o       (trap_o),
      .busy_o       (trap_busy_o)
   );

   mret_sequencer mret_seq0 (
      .clk     (clk),
      .reset   (reset),
      .mret_i  (mret_i),
      .rdata_i (rdata),
      .csr_o   (mret_csr),
      .mret_o  (mret_o),
      .busy_o  (mret_busy_o)
   );

   csr_rmw_unit rmw0 (
      .clk     (clk),
      .reset   (reset),
      .cmd_i   (csr_cmd_i),
      .rdata_i (rdata),
      .csr_o   (sw_csr),
      .done_o  (csr_done_o),
      .old_o   (csr_old_o)
   );

endmodule

`default_nettype wire

// ==== hdl/csr_rmw_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_rmw_unit (
   input  wire                      clk,
   input  wire                      reset,
   input  wire trap_pkg::csr_cmd_t  cmd_i,
   input  wire csr_pkg::xlen_t      rdata_i,
   output trap_pkg::csr_req_t       csr_o,
   output logic                     done_o,
   output csr_pkg::xlen_t           old_o
);

   import csr_pkg::*;
   import trap_pkg::*;

   logic     pending_q;   // Command held for its RMW cycle
   csr_cmd_t cmd_q;
   xlen_t    operand;
   xlen_t    wdata;

   always_ff @(posedge clk) begin
      if (reset) begin
         pending_q <= 1'b0;
      end else begin
         pending_q <= cmd_i.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (cmd_i.valid) cmd_q <= cmd_i;
   end

   // Immediate forms carry funct3 bit 2
   assign operand = cmd_q.op[2] ? xlen_t'(cmd_q.zimm) : cmd_q.rs1_val;

   always_comb begin
      case (cmd_q.op)
         CSRRW, CSRRWI: wdata = operand;
         CSRRS, CSRRSI: wdata = rdata_i | operand;
         CSRRC, CSRRCI: wdata = rdata_i & ~operand;
         default:       wdata = rdata_i;   // Reserved funct3, value kept
      endcase
   end

   always_comb begin
      csr_o.en    = pending_q;
      csr_o.we    = pending_q;
      csr_o.addr  = cmd_q.addr;
      csr_o.wdata = wdata;
   end

   assign done_o = pending_q;
   assign old_o  = rdata_i;   // Value before the write lands

endmodule

`default_nettype wire

// ==== hdl/mret_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module mret_sequencer (
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  mret_i,
   input  wire csr_pkg::xlen_t  rdata_i,
   output trap_pkg::csr_req_t   csr_o,
   output trap_pkg::redirect_t  mret_o,
   output logic                 busy_o
);

   import csr_pkg::*;

   typedef enum logic [1:0] {IDLE, STATUS, EPC} state_t;

   state_t state_q, state_d;
   xlen_t  status_new;

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_comb begin
      state_d    = state_q;
      csr_o      = '0;
      mret_o     = '0;
      status_new = rdata_i;
      status_new[MSTATUS_MIE] = rdata_i[MSTATUS_MPIE];   // Restore MIE

      case (state_q)
         IDLE: if (mret_i) state_d = STATUS;
         STATUS: begin
            csr_o   = '{en: 1'b1, we: 1'b1, addr: CSR_MSTATUS, wdata: status_new};
            state_d = EPC;
         end
         EPC: begin
            csr_o   = '{en: 1'b1, we: 1'b0, addr: CSR_MEPC, wdata: '0};
            mret_o  = '{valid: 1'b1, target: rdata_i & ~xlen_t'(1)};
            state_d = IDLE;
         end
         default: state_d = IDLE;
      endcase
   end

   assign busy_o = (state_q != IDLE);

endmodule

`default_nettype wire

// ==== hdl/trap_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module trap_sequencer (
   input  wire                       clk,
   input  wire                       reset,
   input  wire                       exc_valid_i,
   input  wire trap_pkg::exc_kind_t  exc_kind_i,
   input  wire csr_pkg::xlen_t       pc_i,
   input  wire                       timer_irq_i,
   input  wire                       tag_irq_i,
   input  wire                       irq_enable_i,
   input  wire                       timer_en_i,
   input  wire                       tag_en_i,
   input  wire csr_pkg::xlen_t       rdata_i,
   output trap_pkg::csr_req_t        csr_o,
   output trap_pkg::redirect_t       trap_o,
   output logic                      busy_o
);

   import csr_pkg::*;
   import trap_pkg::*;

   typedef enum logic [2:0] {IDLE, CAUSE, STATUS, EPC, TVAL, MIP, TVEC} state_t;

   state_t state_q, state_d;

   logic  timer_take;
   logic  tag_take;
   logic  accept;
   logic  timer_q;      // Trap taken for the timer
   xlen_t cause_d;
   xlen_t cause_q;
   xlen_t pc_q;
   xlen_t status_new;

   // Interrupts gated by the global and per-source enables
   assign timer_take = timer_irq_i & timer_en_i & irq_enable_i;
   assign tag_take   = tag_irq_i & tag_en_i & irq_enable_i;
   assign accept     = (state_q == IDLE) & (timer_take | tag_take | exc_valid_i);

   always_comb begin
      if (timer_take) begin
         cause_d = CAUSE_TIMER;
      end else if (tag_take) begin
         cause_d = CAUSE_TAG;
      end else begin
         case (exc_kind_i)
            ECALL:   cause_d = CAUSE_ECALL;
            EBREAK:  cause_d = CAUSE_BREAK;
            ILLEGAL: cause_d = CAUSE_ILLEGAL;
            default: cause_d = CAUSE_MISALIGNED;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= IDLE;
         timer_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (accept) timer_q <= timer_take;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cause_q <= cause_d;
         pc_q    <= pc_i;
      end
   end

   // ========================================
   // Trap entry steps
   // ========================================
   always_comb begin
      state_d    = state_q;
      csr_o      = '0;
      trap_o     = '0;
      status_new = rdata_i;
      status_new[MSTATUS_MPIE] = rdata_i[MSTATUS_MIE];
      status_new[MSTATUS_MIE]  = 1'b0;

      case (state_q)
         IDLE: if (accept) state_d = CAUSE;
         CAUSE: begin
            csr_o   = '{en: 1'b1, we: 1'b1, addr: CSR_MCAUSE, wdata: cause_q};
            state_d = STATUS;
         end
         STATUS: begin
            csr_o   = '{en: 1'b1, we: 1'b1, addr: CSR_MSTATUS, wdata: status_new};
            state_d = EPC;
         end
         EPC: begin
            csr_o   = '{en: 1'b1, we: 1'b1, addr: CSR_MEPC, wdata: pc_q};
            state_d = TVAL;
         end
         TVAL: begin
            csr_o   = '{en: 1'b1, we: 1'b1, addr: CSR_MTVAL, wdata: pc_q};
            state_d = timer_q ? MIP : TVEC;
         end
         MIP: begin
            csr_o   = '{en: 1'b1, we: 1'b1, addr: CSR_MIP,
                        wdata: rdata_i | (xlen_t'(1) << MIP_MTIP)};
            state_d = TVEC;
         end
         TVEC: begin
            csr_o   = '{en: 1'b1, we: 1'b0, addr: CSR_MTVEC, wdata: '0};
            trap_o  = '{valid: 1'b1, target: rdata_i & ~xlen_t'(1)};
            state_d = IDLE;
         end
         default: state_d = IDLE;
      endcase
   end

   assign busy_o = (state_q != IDLE);

endmodule

`default_nettype wire

// ==== hdl/csr_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_regfile #(
   parameter csr_pkg::xlen_t MTVEC_RESET = 32'd16
) (
   input  wire                 clk,
   input  wire                 reset,
   input  wire trap_pkg::csr_req_t  trap_csr_i,
   input  wire trap_pkg::csr_req_t  mret_csr_i,
   input  wire trap_pkg::csr_req_t  sw_csr_i,
   output csr_pkg::xlen_t      rdata_o,
   output logic                irq_enable_o,
   output logic                timer_en_o,
   output logic                tag_en_o
);

   import csr_pkg::*;
   import trap_pkg::*;

   xlen_t mstatus_q;
   xlen_t mie_q;
   xlen_t mip_q;
   xlen_t mtvec_q;
   xlen_t mepc_q;
   xlen_t mtval_q;
   xlen_t mcause_q;

   csr_req_t sel;   // Access served this cycle
   logic     wr_en;

   // ========================================
   // Port selection, trap > mret > software
   // ========================================
   always_comb begin
      if (trap_csr_i.en) begin
         sel = trap_csr_i;
      end else if (mret_csr_i.en) begin
         sel = mret_csr_i;
      end else begin
         sel = sw_csr_i;
      end
   end

   assign wr_en = sel.en & sel.we;

   // Combinational read of the served address
   always_comb begin
      case (sel.addr)
         CSR_MSTATUS: rdata_o = mstatus_q;
         CSR_MIE:     rdata_o = mie_q;
         CSR_MIP:     rdata_o = mip_q;
         CSR_MTVEC:   rdata_o = mtvec_q;
         CSR_MEPC:    rdata_o = mepc_q;
         CSR_MTVAL:   rdata_o = mtval_q;
         CSR_MCAUSE:  rdata_o = mcause_q;
         default:     rdata_o = '0;   // Not implemented
      endcase
   end

   // ========================================
   // Register update
   // ========================================
   always_ff @(posedge clk) begin
      if (reset) begin
         mstatus_q <= '0;
         mie_q     <= '0;
         mip_q     <= '0;
         mtvec_q   <= MTVEC_RESET;
         mepc_q    <= '0;
         mtval_q   <= '0;
         mcause_q  <= '0;
      end else if (wr_en) begin
         case (sel.addr)
            CSR_MSTATUS: mstatus_q <= sel.wdata;
            CSR_MIE:     mie_q     <= sel.wdata;
            CSR_MIP:     mip_q     <= sel.wdata;
            CSR_MTVEC:   mtvec_q   <= sel.wdata;
            CSR_MEPC:    mepc_q    <= sel.wdata;
            CSR_MTVAL:   mtval_q   <= sel.wdata;
            CSR_MCAUSE:  mcause_q  <= sel.wdata;
            default: ;   // Write dropped
         endcase
      end
   end

   // Enables seen by the interrupt logic
   assign irq_enable_o = mstatus_q[MSTATUS_MIE];
   assign timer_en_o   = mie_q[MIE_MTIE];
   assign tag_en_o     = mie_q[MIE_TAGE];

endmodule

`default_nettype wire

// ==== hdl/trap_pkg.sv ====
`default_nettype none

package trap_pkg;

   // One CSR port access, valid for a single cycle
   typedef struct packed {
      logic                en;
      logic                we;
      csr_pkg::csr_addr_t  addr;
      csr_pkg::xlen_t      wdata;
   } csr_req_t;

   // Synchronous exception kinds reported by the core
   typedef enum logic [1:0] {
      ECALL,
      EBREAK,
      ILLEGAL,
      MISALIGNED
   } exc_kind_t;

   // funct3 of the SYSTEM CSR instructions
   typedef enum logic [2:0] {
      CSRRW  = 3'd1,
      CSRRS  = 3'd2,
      CSRRC  = 3'd3,
      CSRRWI = 3'd5,
      CSRRSI = 3'd6,
      CSRRCI = 3'd7
   } csr_op_t;

   typedef struct packed {
      logic                valid;
      csr_op_t             op;
      csr_pkg::csr_addr_t  addr;
      csr_pkg::xlen_t      rs1_val;
      logic [4:0]          zimm;
   } csr_cmd_t;

   // pc redirect pulse
   typedef struct packed {
      logic            valid;
      csr_pkg::xlen_t  target;
   } redirect_t;

endpackage

`default_nettype wire

// ==== hdl/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

   // Machine word and CSR address
   typedef logic [31:0] xlen_t;
   typedef logic [11:0] csr_addr_t;

   // ========================================
   // Machine-mode CSR addresses
   // ========================================
   localparam csr_addr_t CSR_MSTATUS = 12'h300;
   localparam csr_addr_t CSR_MIE     = 12'h304;
   localparam csr_addr_t CSR_MTVEC   = 12'h305;
   localparam csr_addr_t CSR_MEPC    = 12'h341;
   localparam csr_addr_t CSR_MCAUSE  = 12'h342;
   localparam csr_addr_t CSR_MTVAL   = 12'h343;
   localparam csr_addr_t CSR_MIP     = 12'h344;

   // mstatus fields
   localparam int MSTATUS_MIE  = 3;
   localparam int MSTATUS_MPIE = 7;

   // mie / mip fields
   localparam int MIE_MTIE = 7;
   localparam int MIP_MTIP = 7;
   localparam int MIE_TAGE = 16;   // Tag mismatch enable, custom bit

   // ========================================
   // mcause codes
   // ========================================
   // Synchronous exceptions
   localparam xlen_t CAUSE_MISALIGNED = 32'h0000_0000;
   localparam xlen_t CAUSE_ILLEGAL    = 32'h0000_0002;
   localparam xlen_t CAUSE_BREAK      = 32'h0000_0003;
   localparam xlen_t CAUSE_ECALL      = 32'h0000_000b;

   // Interrupts, top bit set
   localparam xlen_t CAUSE_TIMER = 32'h8000_0007;
   localparam xlen_t CAUSE_TAG   = 32'h8000_0010;

endpackage

`default_nettype wire
